// ==== logic/simd_pkg.sv ====
`default_nettype none

package simd_pkg;

    ////////////////////////////////////////
    // Datapath sizes
    ////////////////////////////////////////
    localparam int lane_count       = 4;
    localparam int data_width       = 32;
    localparam int vector_width     = lane_count * data_width;
    localparam int reg_count        = 8;
    localparam int reg_index_width  = 3;
    localparam int lane_index_width = 2;

    ////////////////////////////////////////
    // APB address map
    ////////////////////////////////////////
    localparam int addr_width = 12;
    localparam logic [addr_width-1:0] issue_addr  = 12'h000;
    localparam logic [addr_width-1:0] scalar_base = 12'h100;
    localparam logic [addr_width-1:0] vector_base = 12'h200;
    // Bytes covered by each bank window
    localparam int scalar_span = reg_count * 4;
    localparam int vector_span = reg_count * lane_count * 4;

    // Instruction word fields
    localparam int opcode_msb = 31;
    localparam int opcode_lsb = 28;
    localparam int dst_lsb    = 8;
    localparam int src1_lsb   = 4;
    localparam int src2_lsb   = 0;

    // Codes 0 and 9 to 15 are no-ops
    typedef enum logic [3:0] {
        op_vadd  = 4'h1,
        op_vsub  = 4'h2,
        op_vand  = 4'h3,
        op_vxor  = 4'h4,
        op_vadds = 4'h5,
        op_vmuls = 4'h6,
        op_vred  = 4'h7,
        op_sadd  = 4'h8
    } opcode_t;

    typedef enum logic [2:0] {
        lane_add,
        lane_sub,
        lane_and,
        lane_xor,
        lane_mul,
        lane_pass
    } lane_op_t;

    typedef enum logic [1:0] {
        wb_none,
        wb_vector,
        wb_scalar,
        wb_reduce
    } wb_kind_t;

endpackage

`default_nettype wire

// ==== logic/apb_slave.sv ====
`default_nettype none

module apb_slave (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic [simd_pkg::addr_width-1:0]      paddr,
    input  logic                                 psel,
    input  logic                                 penable,
    input  logic                                 pwrite,
    input  logic [simd_pkg::data_width-1:0]      pwdata,
    input  logic                                 busy,
    output logic [simd_pkg::data_width-1:0]      prdata,
    output logic                                 pready,
    output logic                                 pslverr,
    output logic                                 host_we,
    output logic                                 host_vector_sel,
    output logic [simd_pkg::reg_index_width-1:0] host_index,
    output logic [simd_pkg::lane_index_width-1:0] host_lane,
    output logic [simd_pkg::data_width-1:0]      host_wdata,
    output logic                                 issue,
    output logic [simd_pkg::data_width-1:0]      issue_word,
    input  logic [simd_pkg::data_width-1:0]      scalar_rdata,
    input  logic [simd_pkg::data_width-1:0]      vector_lane_rdata
);
    import simd_pkg::*;

    logic scalar_hit;
    logic vector_hit;
    logic issue_hit;
    logic addr_error;
    logic access;
    logic done_q;

    ////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////
    assign issue_hit  = (paddr == issue_addr);
    assign scalar_hit = (paddr >= scalar_base) && (paddr < scalar_base + scalar_span)
                        && (paddr[1:0] == 2'b00);
    assign vector_hit = (paddr >= vector_base) && (paddr < vector_base + vector_span)
                        && (paddr[1:0] == 2'b00);

    // Unmapped, or a read of the issue word
    assign addr_error = !(scalar_hit || vector_hit || issue_hit) || (issue_hit && !pwrite);

    // Register index sits higher in the vector window
    assign host_index      = vector_hit ? paddr[4 +: reg_index_width]
                                        : paddr[2 +: reg_index_width];
    assign host_lane       = paddr[2 +: lane_index_width];
    assign host_vector_sel = vector_hit;
    assign host_wdata      = pwdata;
    assign issue_word      = pwdata;

    ////////////////////////////////////////
    // Handshake and strobes
    ////////////////////////////////////////
    assign access  = psel && penable && !done_q;
    assign pready  = access && !busy;
    assign pslverr = pready && addr_error;

    assign host_we = pready && pwrite && (scalar_hit || vector_hit);
    assign issue   = pready && pwrite && issue_hit;

    assign prdata = vector_hit ? vector_lane_rdata :
                    scalar_hit ? scalar_rdata      : '0;

    // No second completion while penable is still held from the last one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_q <= 1'b0;
        end else begin
            done_q <= pready;
        end
    end

endmodule

`default_nettype wire

// ==== logic/register_bank.sv ====
`default_nettype none

module register_bank (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  host_we,
    input  logic                                  host_vector_sel,
    input  logic [simd_pkg::reg_index_width-1:0]  host_index,
    input  logic [simd_pkg::lane_index_width-1:0] host_lane,
    input  logic [simd_pkg::data_width-1:0]       host_wdata,
    input  logic                                  wb_scalar_we,
    input  logic                                  wb_vector_we,
    input  logic [simd_pkg::reg_index_width-1:0]  wb_index,
    input  logic [simd_pkg::data_width-1:0]       wb_scalar_data,
    input  logic [simd_pkg::vector_width-1:0]     wb_vector_data,
    output logic [simd_pkg::data_width-1:0]       scalar_rdata,
    output logic [simd_pkg::data_width-1:0]       vector_lane_rdata,
    input  logic [simd_pkg::reg_index_width-1:0]  src1,
    input  logic [simd_pkg::reg_index_width-1:0]  src2,
    output logic [simd_pkg::data_width-1:0]       scalar1,
    output logic [simd_pkg::data_width-1:0]       scalar2,
    output logic [simd_pkg::vector_width-1:0]     vector1,
    output logic [simd_pkg::vector_width-1:0]     vector2
);
    import simd_pkg::*;

    logic [data_width-1:0]   sregs [reg_count];
    logic [vector_width-1:0] vregs [reg_count];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < reg_count; i++) begin
                sregs[i] <= '0;
                vregs[i] <= '0;
            end
        end else begin
            if (wb_scalar_we) begin
                sregs[wb_index] <= wb_scalar_data;
            end
            if (wb_vector_we) begin
                vregs[wb_index] <= wb_vector_data;
            end
            // Host is stalled while a writeback is pending
            if (host_we) begin
                if (host_vector_sel) begin
                    vregs[host_index][host_lane*data_width +: data_width] <= host_wdata;
                end else begin
                    sregs[host_index] <= host_wdata;
                end
            end
        end
    end

    // Host read port
    assign scalar_rdata      = sregs[host_index];
    assign vector_lane_rdata = vregs[host_index][host_lane*data_width +: data_width];

    // Operand read ports
    assign scalar1 = sregs[src1];
    assign scalar2 = sregs[src2];
    assign vector1 = vregs[src1];
    assign vector2 = vregs[src2];

endmodule

`default_nettype wire

// ==== logic/issue_decoder.sv ====
`default_nettype none

module issue_decoder (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 issue,
    input  logic [simd_pkg::data_width-1:0]      issue_word,
    input  logic [simd_pkg::data_width-1:0]      scalar1,
    input  logic [simd_pkg::data_width-1:0]      scalar2,
    input  logic [simd_pkg::vector_width-1:0]    vector1,
    input  logic [simd_pkg::vector_width-1:0]    vector2,
    output logic [simd_pkg::reg_index_width-1:0] src1,
    output logic [simd_pkg::reg_index_width-1:0] src2,
    output logic [simd_pkg::lane_count-1:0]      lane_valid,
    output simd_pkg::lane_op_t                   lane_op,
    output logic [simd_pkg::vector_width-1:0]    op_a,
    output logic [simd_pkg::vector_width-1:0]    op_b,
    output simd_pkg::wb_kind_t                   wb_kind,
    output logic [simd_pkg::reg_index_width-1:0] wb_dst
);
    import simd_pkg::*;

    opcode_t                opcode;
    logic [lane_count-1:0]  next_valid;
    lane_op_t               next_op;
    logic [vector_width-1:0] next_a;
    logic [vector_width-1:0] next_b;
    wb_kind_t               next_kind;

    assign opcode = opcode_t'(issue_word[opcode_msb:opcode_lsb]);
    assign src1   = issue_word[src1_lsb +: reg_index_width];
    assign src2   = issue_word[src2_lsb +: reg_index_width];

    always_comb begin
        next_valid = '1;
        next_op    = lane_pass;
        next_a     = vector1;
        next_b     = vector2;
        next_kind  = wb_vector;
        case (opcode)
            op_vadd:  next_op = lane_add;
            op_vsub:  next_op = lane_sub;
            op_vand:  next_op = lane_and;
            op_vxor:  next_op = lane_xor;
            op_vadds: begin
                next_op = lane_add;
                next_b  = {lane_count{scalar2}};
            end
            op_vmuls: begin
                next_op = lane_mul;
                next_b  = {lane_count{scalar2}};
            end
            op_vred:  next_kind = wb_reduce;
            op_sadd: begin
                // Scalar add runs in lane 0 only
                next_valid = 'b1;
                next_op    = lane_add;
                next_a     = vector_width'(scalar1);
                next_b     = vector_width'(scalar2);
                next_kind  = wb_scalar;
            end
            default: begin
                next_valid = '0;
                next_kind  = wb_none;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lane_valid <= '0;
            lane_op    <= lane_pass;
            wb_kind    <= wb_none;
        end else begin
            lane_valid <= issue ? next_valid : '0;
            wb_kind    <= issue ? next_kind : wb_none;
            if (issue) begin
                lane_op <= next_op;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            op_a   <= next_a;
            op_b   <= next_b;
            wb_dst <= issue_word[dst_lsb +: reg_index_width];
        end
    end

endmodule

`default_nettype wire

// ==== logic/simd_lane.sv ====
`default_nettype none

module simd_lane (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            in_valid,
    input  simd_pkg::lane_op_t              op,
    input  logic [simd_pkg::data_width-1:0] op_a,
    input  logic [simd_pkg::data_width-1:0] op_b,
    output logic [simd_pkg::data_width-1:0] result,
    output logic                            out_valid
);
    import simd_pkg::*;

    logic [data_width-1:0] alu_out;

    // Integer ALU, products keep the low word
    always_comb begin
        case (op)
            lane_add: alu_out = op_a + op_b;
            lane_sub: alu_out = op_a - op_b;
            lane_and: alu_out = op_a & op_b;
            lane_xor: alu_out = op_a ^ op_b;
            lane_mul: alu_out = op_a * op_b;
            default:  alu_out = op_a;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            result <= alu_out;
        end
    end

endmodule

`default_nettype wire

// ==== logic/writeback_collector.sv ====
`default_nettype none

module writeback_collector (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic [simd_pkg::vector_width-1:0]    lane_result,
    input  logic [simd_pkg::lane_count-1:0]      lane_valid,
    input  simd_pkg::wb_kind_t                   wb_kind,
    input  logic [simd_pkg::reg_index_width-1:0] wb_dst,
    output logic                                 busy,
    output logic                                 wb_scalar_we,
    output logic                                 wb_vector_we,
    output logic [simd_pkg::reg_index_width-1:0] wb_index,
    output logic [simd_pkg::data_width-1:0]      wb_scalar_data,
    output logic [simd_pkg::vector_width-1:0]    wb_vector_data
);
    import simd_pkg::*;

    wb_kind_t              kind_q;
    logic [reg_index_width-1:0] dst_q;
    logic [data_width-1:0] lane_sum;
    logic                  all_valid;

    // Second stage of the target, in step with the lane results
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            kind_q <= wb_none;
        end else begin
            kind_q <= wb_kind;
        end
    end

    always_ff @(posedge clk) begin
        dst_q <= wb_dst;
    end

    ////////////////////////////////////////
    // Reduction and write ports
    ////////////////////////////////////////
    always_comb begin
        lane_sum = '0;
        for (int i = 0; i < lane_count; i++) begin
            lane_sum = lane_sum + lane_result[i*data_width +: data_width];
        end
    end

    assign all_valid = &lane_valid;

    assign wb_vector_we   = (kind_q == wb_vector) && all_valid;
    assign wb_scalar_we   = ((kind_q == wb_scalar) && lane_valid[0])
                            || ((kind_q == wb_reduce) && all_valid);
    assign wb_index       = dst_q;
    assign wb_scalar_data = (kind_q == wb_reduce) ? lane_sum : lane_result[data_width-1:0];
    assign wb_vector_data = lane_result;

    // Occupied while either stage holds an instruction
    assign busy = (wb_kind != wb_none) || (kind_q != wb_none);

endmodule

`default_nettype wire

// ==== logic/simd_core_top.sv ====
`default_nettype none

module simd_core_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [simd_pkg::addr_width-1:0] paddr,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [simd_pkg::data_width-1:0] pwdata,
    output logic [simd_pkg::data_width-1:0] prdata,
    output logic                            pready,
    output logic                            pslverr
);
    import simd_pkg::*;

    logic                        busy;
    logic                        host_we;
    logic                        host_vector_sel;
    logic [reg_index_width-1:0]  host_index;
    logic [lane_index_width-1:0] host_lane;
    logic [data_width-1:0]       host_wdata;
    logic                        issue;
    logic [data_width-1:0]       issue_word;
    logic [data_width-1:0]       scalar_rdata;
    logic [data_width-1:0]       vector_lane_rdata;

    logic [reg_index_width-1:0]  src1;
    logic [reg_index_width-1:0]  src2;
    logic [data_width-1:0]       scalar1;
    logic [data_width-1:0]       scalar2;
    logic [vector_width-1:0]     vector1;
    logic [vector_width-1:0]     vector2;

    logic [lane_count-1:0]       lane_valid;
    lane_op_t                    lane_op;
    logic [vector_width-1:0]     op_a;
    logic [vector_width-1:0]     op_b;
    wb_kind_t                    wb_kind;
    logic [reg_index_width-1:0]  wb_dst;
    logic [vector_width-1:0]     lane_result;
    logic [lane_count-1:0]       lane_out_valid;

    logic                        wb_scalar_we;
    logic                        wb_vector_we;
    logic [reg_index_width-1:0]  wb_index;
    logic [data_width-1:0]       wb_scalar_data;
    logic [vector_width-1:0]     wb_vector_data;

    apb_slave u_apb (
        .clk(clk), .rst_n(rst_n),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
        .busy(busy), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .host_we(host_we), .host_vector_sel(host_vector_sel), .host_index(host_index),
        .host_lane(host_lane), .host_wdata(host_wdata),
        .issue(issue), .issue_word(issue_word),
        .scalar_rdata(scalar_rdata), .vector_lane_rdata(vector_lane_rdata)
    );

    register_bank u_bank (
        .clk(clk), .rst_n(rst_n),
        .host_we(host_we), .host_vector_sel(host_vector_sel), .host_index(host_index),
        .host_lane(host_lane), .host_wdata(host_wdata),
        .wb_scalar_we(wb_scalar_we), .wb_vector_we(wb_vector_we), .wb_index(wb_index),
        .wb_scalar_data(wb_scalar_data), .wb_vector_data(wb_vector_data),
        .scalar_rdata(scalar_rdata), .vector_lane_rdata(vector_lane_rdata),
        .src1(src1), .src2(src2),
        .scalar1(scalar1), .scalar2(scalar2), .vector1(vector1), .vector2(vector2)
    );

    issue_decoder u_decoder (
        .clk(clk), .rst_n(rst_n),
        .issue(issue), .issue_word(issue_word),
        .scalar1(scalar1), .scalar2(scalar2), .vector1(vector1), .vector2(vector2),
        .src1(src1), .src2(src2),
        .lane_valid(lane_valid), .lane_op(lane_op), .op_a(op_a), .op_b(op_b),
        .wb_kind(wb_kind), .wb_dst(wb_dst)
    );

    ////////////////////////////////////////
    // Lanes
    ////////////////////////////////////////
    for (genvar g = 0; g < lane_count; g++) begin : g_lane
        simd_lane u_lane (
            .clk(clk), .rst_n(rst_n),
            .in_valid(lane_valid[g]), .op(lane_op),
            .op_a(op_a[g*data_width +: data_width]),
            .op_b(op_b[g*data_width +: data_width]),
            .result(lane_result[g*data_width +: data_width]),
            .out_valid(lane_out_valid[g])
        );
    end

    writeback_collector u_collector (
        .clk(clk), .rst_n(rst_n),
        .lane_result(lane_result), .lane_valid(lane_out_valid),
        .wb_kind(wb_kind), .wb_dst(wb_dst),
        .busy(busy), .wb_scalar_we(wb_scalar_we), .wb_vector_we(wb_vector_we),
        .wb_index(wb_index), .wb_scalar_data(wb_scalar_data),
        .wb_vector_data(wb_vector_data)
    );

endmodule

`default_nettype wire

// ==== verification/simd_core_props.sv ====
`default_nettype none

module simd_core_props (
    input logic clk,
    input logic rst_n,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic pslverr,
    input logic busy,
    input logic host_we,
    input logic wb_scalar_we,
    input logic wb_vector_we
);
    timeunit 1ns;
    timeprecision 100ps;

    // A stalled access keeps select and enable
    a_psel_stable: assert property (@(posedge clk) disable iff (!rst_n)
        psel && penable && !pready |=> psel && penable)
        else $error("psel or penable dropped during a stalled transfer");

    // Errored transfer completes and starts no instruction
    a_err_with_ready: assert property (@(posedge clk) disable iff (!rst_n)
        pslverr |-> pready ##1 !busy)
        else $error("errored transfer without pready or followed by busy");

    // Busy keeps the host off the bank during writeback
    a_wb_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(host_we && (wb_scalar_we || wb_vector_we)))
        else $error("host write in the same cycle as a writeback");

    // One instruction in flight at most
    a_busy_bounded: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(busy) |-> ##[1:3] !busy)
        else $error("busy held longer than three cycles");

endmodule

bind simd_core_top simd_core_props u_props (
    .clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pready(pready),
    .pslverr(pslverr), .busy(busy), .host_we(host_we), .wb_scalar_we(wb_scalar_we),
    .wb_vector_we(wb_vector_we)
);

`default_nettype wire

// ==== verification/simd_core_tb.sv ====
`default_nettype none

module simd_core_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import simd_pkg::*;

    localparam int clk_period = 100;
    localparam int wait_limit = 20;

    logic                  clk;
    logic                  rst_n;
    logic [addr_width-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [data_width-1:0] pwdata;
    logic [data_width-1:0] prdata;
    logic                  pready;
    logic                  pslverr;

    int                    seed = 97;
    int                    last_waits;
    logic [data_width-1:0] sreg_model [reg_count];
    logic [data_width-1:0] vreg_model [reg_count][lane_count];
    logic [data_width-1:0] got_q [$];
    logic [data_width-1:0] exp_q [$];
    string                 name_q [$];

    simd_core_top UUT (
        .clk(clk), .rst_n(rst_n), .paddr(paddr), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2);
            clk = ~clk;
        end
    end

    ////////////////////////////////////////
    // Reporting
    ////////////////////////////////////////
    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [data_width-1:0] got,
                               input logic [data_width-1:0] expected);
        if (got !== expected) begin
            stop_with_failure($sformatf("Error at %0t ns: %s is %h, expected %h",
                                        $time, name, got, expected));
        end
    endtask

    task automatic queue_check(input string name, input logic [data_width-1:0] got,
                               input logic [data_width-1:0] expected);
        name_q.push_back(name);
        got_q.push_back(got);
        exp_q.push_back(expected);
    endtask

    // Compares whatever the stimulus has collected
    initial begin
        forever begin
            @(negedge clk);
            while (got_q.size() != 0) begin
                check_value(name_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
            end
        end
    end

    ////////////////////////////////////////
    // APB master
    ////////////////////////////////////////
    // Starts and ends on a falling edge, pready sampled mid low phase
    task automatic apb_transfer(input logic write, input logic [addr_width-1:0] addr,
                                input logic [data_width-1:0] wdata,
                                output logic [data_width-1:0] rdata, output logic err);
        int waits;
        waits   = 0;
        paddr   = addr;
        pwrite  = write;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        #(clk_period / 4);
        while (!pready) begin
            if (waits == wait_limit) begin
                stop_with_failure("APB transfer timed out waiting for pready");
            end
            @(negedge clk);
            #(clk_period / 4);
            waits++;
        end
        rdata      = prdata;
        err        = pslverr;
        last_waits = waits;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    function automatic logic [addr_width-1:0] scalar_addr(input int i);
        return scalar_base + addr_width'(4 * i);
    endfunction

    function automatic logic [addr_width-1:0] lane_addr(input int i, input int j);
        return vector_base + addr_width'(16 * i + 4 * j);
    endfunction

    task automatic write_register(input logic [addr_width-1:0] addr,
                                  input logic [data_width-1:0] value);
        logic [data_width-1:0] rdata;
        logic                  err;
        apb_transfer(1'b1, addr, value, rdata, err);
        queue_check($sformatf("pslverr write %h", addr), 32'(err), 32'd0);
    endtask

    task automatic expect_read(input logic [addr_width-1:0] addr,
                               input logic [data_width-1:0] expected, input string name);
        logic [data_width-1:0] rdata;
        logic                  err;
        apb_transfer(1'b0, addr, '0, rdata, err);
        queue_check({"prdata ", name}, rdata, expected);
        queue_check({"pslverr ", name}, 32'(err), 32'd0);
    endtask

    task automatic expect_error(input logic write, input logic [addr_width-1:0] addr);
        logic [data_width-1:0] rdata;
        logic                  err;
        apb_transfer(write, addr, 32'hdead_beef, rdata, err);
        queue_check($sformatf("pslverr at %h", addr), 32'(err), 32'd1);
    endtask

    task automatic check_all_registers();
        for (int i = 0; i < reg_count; i++) begin
            expect_read(scalar_addr(i), sreg_model[i], $sformatf("scalar %0d", i));
            for (int j = 0; j < lane_count; j++) begin
                expect_read(lane_addr(i, j), vreg_model[i][j],
                            $sformatf("vector %0d lane %0d", i, j));
            end
        end
    endtask

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////
    function automatic void apply_reference(input logic [data_width-1:0] word);
        logic [3:0]            op;
        int                    d;
        int                    a;
        int                    b;
        logic [data_width-1:0] lanes [lane_count];
        logic [data_width-1:0] sum;
        op  = word[31:28];
        d   = int'(word[10:8]);
        a   = int'(word[6:4]);
        b   = int'(word[2:0]);
        sum = '0;
        for (int j = 0; j < lane_count; j++) begin
            case (op)
                op_vadd:  lanes[j] = vreg_model[a][j] + vreg_model[b][j];
                op_vsub:  lanes[j] = vreg_model[a][j] - vreg_model[b][j];
                op_vand:  lanes[j] = vreg_model[a][j] & vreg_model[b][j];
                op_vxor:  lanes[j] = vreg_model[a][j] ^ vreg_model[b][j];
                op_vadds: lanes[j] = vreg_model[a][j] + sreg_model[b];
                op_vmuls: lanes[j] = vreg_model[a][j] * sreg_model[b];
                default:  lanes[j] = vreg_model[a][j];
            endcase
            sum = sum + vreg_model[a][j];
        end
        if (op >= 4'h1 && op <= 4'h6) begin
            for (int j = 0; j < lane_count; j++) begin
                vreg_model[d][j] = lanes[j];
            end
        end else if (op == op_vred) begin
            sreg_model[d] = sum;
        end else if (op == op_sadd) begin
            sreg_model[d] = sreg_model[a] + sreg_model[b];
        end
    endfunction

    task automatic issue_instruction(input logic [3:0] op, input logic [2:0] d,
                                     input logic [2:0] a, input logic [2:0] b);
        logic [data_width-1:0] word;
        word = {op, 17'd0, d, 1'b0, a, 1'b0, b};
        write_register(issue_addr, word);
        apply_reference(word);
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////
    initial begin
        int drain;
        rst_n   = 1'b0;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        for (int i = 0; i < reg_count; i++) begin
            sreg_model[i] = '0;
            for (int j = 0; j < lane_count; j++) begin
                vreg_model[i][j] = '0;
            end
        end
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        // Round trip through every register
        for (int i = 0; i < reg_count; i++) begin
            sreg_model[i] = $random(seed);
            write_register(scalar_addr(i), sreg_model[i]);
            for (int j = 0; j < lane_count; j++) begin
                vreg_model[i][j] = $random(seed);
                write_register(lane_addr(i, j), vreg_model[i][j]);
            end
        end
        check_all_registers();
        expect_error(1'b0, issue_addr);
        expect_error(1'b0, 12'h120);
        expect_error(1'b0, 12'h102);
        expect_error(1'b1, 12'h280);
        expect_error(1'b1, 12'h3fc);
        expect_error(1'b1, 12'h105);
        check_all_registers();

        // Every defined opcode on random registers
        for (int k = 1; k <= 8; k++) begin
            repeat (3) begin
                issue_instruction(4'(k), 3'($random(seed)), 3'($random(seed)),
                                  3'($random(seed)));
                check_all_registers();
            end
        end

        // Wraparound
        sreg_model[1] = 32'hffff_fffe;
        sreg_model[2] = 32'h0000_0005;
        write_register(scalar_addr(1), sreg_model[1]);
        write_register(scalar_addr(2), sreg_model[2]);
        for (int j = 0; j < lane_count; j++) begin
            vreg_model[6][j] = 32'hffff_fff0 + j;
            write_register(lane_addr(6, j), vreg_model[6][j]);
        end
        issue_instruction(op_sadd, 3'd3, 3'd1, 3'd2);
        issue_instruction(op_vadds, 3'd7, 3'd6, 3'd1);
        issue_instruction(op_vmuls, 3'd0, 3'd6, 3'd1);
        issue_instruction(op_vred, 3'd4, 3'd6, 3'd0);
        check_all_registers();

        // Read straight after an issue must stall until writeback
        issue_instruction(op_vadd, 3'd5, 3'd6, 3'd7);
        expect_read(lane_addr(5, 2), vreg_model[5][2], "vector 5 lane 2 after issue");
        queue_check("stall cycles nonzero", 32'(last_waits != 0), 32'd1);
        issue_instruction(op_vred, 3'd2, 3'd5, 3'd0);
        expect_read(scalar_addr(2), sreg_model[2], "scalar 2 after issue");

        // Undefined opcodes
        issue_instruction(4'h0, 3'd1, 3'd2, 3'd3);
        issue_instruction(4'hf, 3'd6, 3'd5, 3'd4);
        check_all_registers();

        drain = 0;
        while (got_q.size() != 0 && drain < wait_limit) begin
            @(negedge clk);
            drain++;
        end
        if (got_q.size() == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            stop_with_failure("Checker did not consume all collected results");
        end
    end

endmodule

`default_nettype wire

// ==== simd_core.f ====
logic/simd_pkg.sv
logic/apb_slave.sv
logic/register_bank.sv
logic/issue_decoder.sv
logic/simd_lane.sv
logic/writeback_collector.sv
logic/simd_core_top.sv
verification/simd_core_props.sv
verification/simd_core_tb.sv

// ==== Makefile ====
TOP := simd_core_tb
LOG := sim.log

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -f simd_core.f --top-module $(TOP) -Mdir obj_dir
	-./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q '\*\*\* PASSED \*\*\*' $(LOG) || (echo "Simulation did not complete"; exit 1)

lint:
	verilator --lint-only -Wall --timing -f simd_core.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
